// File: source/ex_pkg.sv
//////////////////////////////
// Execute stage package
// Shared widths, operator encodings and the
// request and write-port structs of the EX stage
//////////////////////////////

package ex_pkg;

  // Data word for operands, results, CSR and load data
  typedef logic [31:0] word_t;

  // Integer register file address
  typedef logic [4:0] reg_addr_t;

  //////////////////////////////
  // Operator encodings
  //////////////////////////////

  // ALU operators, compares start at ALU_SLT
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Low word product and the three high word variants
  typedef enum logic [1:0] {
    MULT_MUL,
    MULT_MULH,
    MULT_MULHSU,
    MULT_MULHU
  } mult_op_e;

  // Multiplier sequence
  typedef enum logic [0:0] {
    MULT_IDLE,
    MULT_STEP
  } mult_state_e;

  //////////////////////////////
  // Request and write structs
  //////////////////////////////

  typedef struct packed {
    alu_op_e op;
    word_t   operand_a;
    word_t   operand_b;
  } alu_req_t;

  typedef struct packed {
    mult_op_e op;
    word_t    operand_a;
    word_t    operand_b;
  } mult_req_t;

  // Shared by the forwarding and the load write port
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } rf_write_t;

endpackage

// File: source/ex_alu.sv
//////////////////////////////
// EX stage ALU
// Single-cycle add/sub, logic, shifts, set-less-than
// and the branch comparison
//////////////////////////////

`timescale 1ns/10ps

module ex_alu
  import ex_pkg::*;
(
  input  alu_req_t alu_req_i,
  output word_t    result_o,
  output logic     cmp_o
);

  logic        is_sub;
  logic        is_signed;
  logic        is_cmp;
  logic [32:0] a_ext;
  logic [32:0] b_ext;
  logic [32:0] sum;
  logic        less;
  logic        equal;
  logic        cmp;
  logic        shift_left;
  logic        shift_arith;
  word_t       shift_in;
  logic [32:0] shift_ext;
  word_t       shift_result;

  //////////////////////////////
  // Adder and comparator
  //////////////////////////////

  // Subtract for sub and all compares
  assign is_sub = (alu_req_i.op != ALU_ADD);
  assign is_signed = alu_req_i.op inside {ALU_SLT, ALU_LT, ALU_GE};
  assign is_cmp = alu_req_i.op inside {ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
                                       ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};

  // One extra bit so signed and unsigned compares share the adder
  assign a_ext = {is_signed & alu_req_i.operand_a[31], alu_req_i.operand_a};
  assign b_ext = {is_signed & alu_req_i.operand_b[31], alu_req_i.operand_b};
  assign sum   = a_ext + (is_sub ? ~b_ext : b_ext) + {32'd0, is_sub};

  // Sign of the 33-bit difference
  assign less  = sum[32];
  assign equal = (sum[31:0] == '0);

  always_comb begin
    case (alu_req_i.op)
      ALU_EQ:                              cmp = equal;
      ALU_NE:                              cmp = ~equal;
      ALU_SLT, ALU_SLTU, ALU_LT, ALU_LTU:  cmp = less;
      ALU_GE, ALU_GEU:                     cmp = ~less;
      default:                             cmp = 1'b0;
    endcase
  end

  //////////////////////////////
  // Barrel shifter
  //////////////////////////////

  assign shift_left  = (alu_req_i.op == ALU_SLL);
  assign shift_arith = (alu_req_i.op == ALU_SRA);

  // Left shifts reverse the operand and use the right shifter
  always_comb begin
    for (int i = 0; i < 32; i++) begin
      shift_in[i] = shift_left ? alu_req_i.operand_a[31-i] : alu_req_i.operand_a[i];
    end
  end

  assign shift_ext = $signed({shift_arith & shift_in[31], shift_in}) >>>
                     alu_req_i.operand_b[4:0];

  // Undo the reversal for left shifts
  always_comb begin
    for (int i = 0; i < 32; i++) begin
      shift_result[i] = shift_left ? shift_ext[31-i] : shift_ext[i];
    end
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ALU_ADD, ALU_SUB:          result_o = sum[31:0];
      ALU_AND:                   result_o = alu_req_i.operand_a & alu_req_i.operand_b;
      ALU_OR:                    result_o = alu_req_i.operand_a | alu_req_i.operand_b;
      ALU_XOR:                   result_o = alu_req_i.operand_a ^ alu_req_i.operand_b;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      default:                   result_o = {31'd0, cmp};
    endcase
  end

  // Branch decision only for compare operators
  assign cmp_o = is_cmp & cmp;

  // Branch decision and set-less-than result agree
  cmp_bit_a: assert final (!is_cmp || (cmp_o == result_o[0]))
    else $error("ALU compare flag differs from result bit 0");

endmodule

// File: source/ex_mult.sv
//////////////////////////////
// EX stage multiplier
// Low word product in one cycle, high word
// variants over HI_CYCLES cycles
//////////////////////////////

`timescale 1ns/10ps

module ex_mult
  import ex_pkg::*;
#(
  parameter int HI_CYCLES = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      en_i,
  input  mult_req_t mult_req_i,
  input  logic      ex_ready_i,
  output word_t     result_o,
  output logic      ready_o,
  output logic      multicycle_o
);

  localparam int CNT_W = (HI_CYCLES > 2) ? $clog2(HI_CYCLES) : 1;

  mult_state_e        state_q;
  mult_state_e        state_d;
  logic [CNT_W-1:0]   cnt_q;
  logic [CNT_W-1:0]   cnt_d;
  logic               sign_a;
  logic               sign_b;
  logic [32:0]        a_ext;
  logic [32:0]        b_ext;
  logic signed [65:0] product;
  logic               hi_op;
  logic               start;
  word_t              prod_hi_q;

  // Operand signedness by operator
  assign sign_a = mult_req_i.op inside {MULT_MULH, MULT_MULHSU};
  assign sign_b = (mult_req_i.op == MULT_MULH);

  assign a_ext   = {sign_a & mult_req_i.operand_a[31], mult_req_i.operand_a};
  assign b_ext   = {sign_b & mult_req_i.operand_b[31], mult_req_i.operand_b};
  assign product = $signed(a_ext) * $signed(b_ext);

  assign hi_op = (mult_req_i.op != MULT_MUL);
  assign start = en_i & hi_op & (state_q == MULT_IDLE);

  //////////////////////////////
  // High word sequence
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    ready_o = 1'b1;
    case (state_q)
      MULT_IDLE: begin
        if (start) begin
          ready_o = 1'b0;
          state_d = MULT_STEP;
          cnt_d   = CNT_W'(HI_CYCLES - 2);
        end
      end
      default: begin
        // Count down, then hold until the stage moves on
        if (cnt_q != '0) begin
          ready_o = 1'b0;
          cnt_d   = cnt_q - 1'b1;
        end else if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Upper half captured on the first cycle
  always_ff @(posedge clk) begin
    if (start) begin
      prod_hi_q <= product[63:32];
    end
  end

  assign result_o     = hi_op ? prod_hi_q : product[31:0];
  assign multicycle_o = (state_q == MULT_STEP);

  // Ready low for exactly HI_CYCLES-1 cycles after a high word start
  hi_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !ready_o [*(HI_CYCLES - 1)] ##1 ready_o);

  // Source holds the request while the result is pending
  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (en_i && !ready_o) |=> $stable(mult_req_i));

endmodule

// File: source/ex_control.sv
//////////////////////////////
// EX stage control
// Ready and valid levels, the EX/WB register
// and both register file write ports
//////////////////////////////

`timescale 1ns/10ps

module ex_control
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  logic      lsu_en_i,
  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  word_t     csr_rdata_i,
  input  word_t     lsu_rdata_i,
  input  logic      mult_ready_i,
  input  logic      lsu_ready_ex_i,
  input  logic      wb_ready_i,
  input  logic      branch_in_ex_i,
  input  logic      regfile_alu_we_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  reg_addr_t regfile_waddr_i,
  output rf_write_t fw_port_o,
  output rf_write_t wb_port_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  logic      units_ready;
  logic      lsu_we_q;
  reg_addr_t lsu_waddr_q;

  //////////////////////////////
  // Stall control
  //////////////////////////////

  // Multiplier, LSU and WB all done
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX without the WB stage
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // Forwarding port, CSR over multiplier over ALU
  always_comb begin
    fw_port_o.we   = regfile_alu_we_i;
    fw_port_o.addr = regfile_alu_waddr_i;
    if (csr_access_i) begin
      fw_port_o.data = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.data = mult_result_i;
    end else if (alu_en_i) begin
      fw_port_o.data = alu_result_i;
    end else begin
      fw_port_o.data = '0;
    end
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      lsu_we_q <= regfile_we_i;
    end else if (wb_ready_i) begin
      // Nothing new arrives, flush the slot
      lsu_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && regfile_we_i) begin
      lsu_waddr_q <= regfile_waddr_i;
    end
  end

  // Load write port, data straight from the LSU
  assign wb_port_o.we   = lsu_we_q & wb_ready_i;
  assign wb_port_o.addr = lsu_waddr_q;
  assign wb_port_o.data = lsu_rdata_i;

  // A stalled WB stage never lets a new load write in
  wb_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> !$rose(lsu_we_q));

endmodule

// File: source/ex_stage.sv
//////////////////////////////
// EX stage top level
// ALU, multiplier and stage control
//////////////////////////////

`timescale 1ns/10ps

module ex_stage
  import ex_pkg::*;
#(
  // High word multiply latency, 2 to 4
  parameter int MULT_HI_CYCLES = 2
) (
  input  logic      clk,
  input  logic      rst_n,

  // ALU request from ID
  input  logic      alu_en_i,
  input  alu_req_t  alu_req_i,
  input  word_t     alu_operand_c_i,

  // Multiplier request from ID
  input  logic      mult_en_i,
  input  mult_req_t mult_req_i,
  output logic      mult_multicycle_o,

  // CSR and LSU
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,

  // Stall inputs
  input  logic      lsu_ready_ex_i,
  input  logic      branch_in_ex_i,
  input  logic      wb_ready_i,

  // Destination registers
  input  logic      regfile_alu_we_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  reg_addr_t regfile_waddr_i,

  // Write ports
  output rf_write_t fw_port_o,
  output rf_write_t wb_port_o,

  // To IF
  output word_t     jump_target_o,
  output logic      branch_decision_o,

  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t alu_result;
  logic  alu_cmp;
  word_t mult_result;
  logic  mult_ready;

  // Branch target is operand C
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = alu_cmp;

  ex_alu u_alu (
    .alu_req_i (alu_req_i),
    .result_o  (alu_result),
    .cmp_o     (alu_cmp)
  );

  ex_mult #(
    .HI_CYCLES (MULT_HI_CYCLES)
  ) u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (mult_en_i),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_control u_control (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .mult_ready_i        (mult_ready),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .wb_ready_i          (wb_ready_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .fw_port_o           (fw_port_o),
    .wb_port_o           (wb_port_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

// File: verification/tb_ex_model.svh
//////////////////////////////
// EX stage testbench model
// Reference ALU, compare and multiply results
// and the stimulus random generator
//////////////////////////////

`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// Generator state, fixed seed
logic [31:0] lcg_state = 32'he312_d06f;

// Halves swapped so the low bits do not just alternate
function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return {lcg_state[15:0], lcg_state[31:16]};
endfunction

// Branch and set-less-than outcome
function automatic logic cmp_model(alu_op_e op, word_t a, word_t b);
  case (op)
    ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
    ALU_SLTU, ALU_LTU: return a < b;
    ALU_EQ:            return a == b;
    ALU_NE:            return a != b;
    ALU_GE:            return $signed(a) >= $signed(b);
    ALU_GEU:           return a >= b;
    default:           return 1'b0;
  endcase
endfunction

function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
  case (op)
    ALU_ADD: return a + b;
    ALU_SUB: return a - b;
    ALU_AND: return a & b;
    ALU_OR:  return a | b;
    ALU_XOR: return a ^ b;
    ALU_SLL: return a << b[4:0];
    ALU_SRL: return a >> b[4:0];
    ALU_SRA: return word_t'($signed(a) >>> b[4:0]);
    // Compares put the flag in bit 0
    default: return {31'd0, cmp_model(op, a, b)};
  endcase
endfunction

// Full 64-bit product, sign handling per operator
function automatic logic [63:0] mult_model(mult_op_e op, word_t a, word_t b);
  case (op)
    MULT_MULH:   return $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    MULT_MULHSU: return $signed({{32{a[31]}}, a}) * $signed({32'd0, b});
    default:     return {32'd0, a} * {32'd0, b};
  endcase
endfunction

`endif

// File: verification/tb_ex_stage.sv
//////////////////////////////
// EX stage testbench
// Random ALU, compare, multiply, write port and
// stall stimulus checked against a reference model
//////////////////////////////

`timescale 1ns/10ps

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int ITEMS     = 200;
  localparam int NUM_TESTS = 6;

  logic      clk;
  logic      rst_n;
  logic      alu_en;
  alu_req_t  alu_req;
  word_t     alu_operand_c;
  logic      mult_en;
  mult_req_t mult_req;
  logic      mult_multicycle;
  logic      csr_access;
  word_t     csr_rdata;
  logic      lsu_en;
  word_t     lsu_rdata;
  logic      lsu_ready_ex;
  logic      branch_in_ex;
  logic      wb_ready;
  logic      regfile_alu_we;
  logic      regfile_we;
  reg_addr_t regfile_alu_waddr;
  reg_addr_t regfile_waddr;
  rf_write_t fw_port;
  rf_write_t wb_port;
  word_t     jump_target;
  logic      branch_decision;
  logic      ex_ready;
  logic      ex_valid;

  int hi_cycles;
  int cycle_limit = 0;
  int cycles      = 0;
  int checks      = 0;
  int errors      = 0;
  int test_errors = 0;
  int tests_done  = 0;

  `include "tb_ex_model.svh"

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ex_stage #(
    .MULT_HI_CYCLES (3)
  ) DUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en),
    .alu_req_i           (alu_req),
    .alu_operand_c_i     (alu_operand_c),
    .mult_en_i           (mult_en),
    .mult_req_i          (mult_req),
    .mult_multicycle_o   (mult_multicycle),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .branch_in_ex_i      (branch_in_ex),
    .wb_ready_i          (wb_ready),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_we_i        (regfile_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_waddr_i     (regfile_waddr),
    .fw_port_o           (fw_port),
    .wb_port_o           (wb_port),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  // Run limit from the number of tests and the multiply latency
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("Fail %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_test(input int num, input string name);
    tests_done++;
    $display("Test %0d %s: %0d items, %0d errors", num, name, ITEMS, test_errors);
    test_errors = 0;
  endtask

  task automatic drive_enables(input logic alu, input logic mult, input logic csr,
                               input logic lsu);
    alu_en     <= alu;
    mult_en    <= mult;
    csr_access <= csr;
    lsu_en     <= lsu;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic alu_result_test();
    logic [31:0] r;
    alu_op_e     op;
    word_t       a;
    word_t       b;
    for (int i = 0; i < ITEMS; i++) begin
      r  = next_rand();
      op = alu_op_e'(r[31:28]);
      a  = next_rand();
      b  = next_rand();
      @(posedge clk);
      drive_enables(1'b1, 1'b0, 1'b0, 1'b0);
      alu_req           <= {op, a, b};
      regfile_alu_we    <= 1'b1;
      regfile_alu_waddr <= r[4:0];
      @(negedge clk);
      check_value("fw_port_o.data", fw_port.data, alu_model(op, a, b));
      check_value("fw_port_o.addr", 32'(fw_port.addr), 32'(r[4:0]));
      check_value("fw_port_o.we", 32'(fw_port.we), 32'd1);
    end
    report_test(1, "ALU results on forwarding port");
  endtask

  task automatic branch_compare_test();
    logic [31:0] r;
    alu_op_e     op;
    word_t       a;
    word_t       b;
    word_t       c;
    for (int i = 0; i < ITEMS; i++) begin
      r  = next_rand();
      op = alu_op_e'({1'b1, r[30:28]});
      a  = next_rand();
      // Equal operands now and then for EQ and GE
      b  = r[27] ? a : next_rand();
      c  = next_rand();
      @(posedge clk);
      drive_enables(1'b1, 1'b0, 1'b0, 1'b0);
      alu_req       <= {op, a, b};
      alu_operand_c <= c;
      @(negedge clk);
      check_value("branch_decision_o", 32'(branch_decision), 32'(cmp_model(op, a, b)));
      check_value("jump_target_o", jump_target, c);
    end
    report_test(2, "branch compare and target");
  endtask

  task automatic multiply_test();
    logic [31:0] r;
    mult_op_e    op;
    word_t       a;
    word_t       b;
    logic [63:0] prod;
    int          waited;
    for (int i = 0; i < ITEMS; i++) begin
      r    = next_rand();
      op   = mult_op_e'(r[29:28]);
      a    = next_rand();
      b    = next_rand();
      prod = mult_model(op, a, b);
      @(posedge clk);
      drive_enables(1'b0, 1'b1, 1'b0, 1'b0);
      mult_req       <= {op, a, b};
      regfile_alu_we <= 1'b1;
      @(negedge clk);
      if (op == MULT_MUL) begin
        check_value("ex_ready_o", 32'(ex_ready), 32'd1);
        check_value("mult_multicycle_o", 32'(mult_multicycle), 32'd0);
        check_value("fw_port_o.data", fw_port.data, prod[31:0]);
      end else begin
        // Request held while the stage stalls
        waited = 0;
        while (ex_ready !== 1'b1 && waited < 8) begin
          check_value("mult_multicycle_o", 32'(mult_multicycle), 32'(waited != 0));
          waited++;
          @(negedge clk);
        end
        check_value("ex_ready_o low cycles", waited, hi_cycles - 1);
        check_value("mult_multicycle_o", 32'(mult_multicycle), 32'd1);
        check_value("fw_port_o.data", fw_port.data, prod[63:32]);
      end
    end
    report_test(3, "multiplier latency and results");
  endtask

  task automatic forward_priority_test();
    logic [31:0] r;
    alu_op_e     op;
    word_t       a;
    word_t       b;
    word_t       ma;
    word_t       mb;
    word_t       csr;
    word_t       exp_data;
    for (int i = 0; i < ITEMS; i++) begin
      r   = next_rand();
      op  = alu_op_e'(r[31:28]);
      a   = next_rand();
      b   = next_rand();
      ma  = next_rand();
      mb  = next_rand();
      csr = next_rand();
      @(posedge clk);
      drive_enables(r[0], r[1], r[2], 1'b0);
      alu_req           <= {op, a, b};
      mult_req          <= {MULT_MUL, ma, mb};
      csr_rdata         <= csr;
      regfile_alu_we    <= r[3];
      regfile_alu_waddr <= r[8:4];
      @(negedge clk);
      if (r[2]) begin
        exp_data = csr;
      end else if (r[1]) begin
        exp_data = ma * mb;
      end else if (r[0]) begin
        exp_data = alu_model(op, a, b);
      end else begin
        exp_data = '0;
      end
      check_value("fw_port_o.data", fw_port.data, exp_data);
      check_value("fw_port_o.we", 32'(fw_port.we), 32'(r[3]));
    end
    report_test(4, "forwarding port priority");
  endtask

  task automatic load_port_test();
    logic [31:0] r;
    word_t       rdata;
    logic        wb;
    logic        lsu_rdy;
    logic        valid;
    logic        we_q;
    reg_addr_t   addr_q;
    // EX/WB register as the model sees it
    we_q   = 1'b0;
    addr_q = '0;
    for (int i = 0; i < ITEMS; i++) begin
      r       = next_rand();
      rdata   = next_rand();
      wb      = r[9] | r[10];
      lsu_rdy = r[11] | r[12];
      @(posedge clk);
      drive_enables(1'b0, 1'b0, r[0], r[1]);
      regfile_we    <= r[2];
      regfile_waddr <= r[8:4];
      lsu_rdata     <= rdata;
      wb_ready      <= wb;
      lsu_ready_ex  <= lsu_rdy;
      @(negedge clk);
      valid = (r[0] | r[1]) & wb & lsu_rdy;
      check_value("ex_valid_o", 32'(ex_valid), 32'(valid));
      check_value("wb_port_o.we", 32'(wb_port.we), 32'(we_q & wb));
      if (we_q) begin
        check_value("wb_port_o.addr", 32'(wb_port.addr), 32'(addr_q));
      end
      check_value("wb_port_o.data", wb_port.data, rdata);
      // Register update on the coming edge
      if (valid) begin
        we_q = r[2];
        if (r[2]) begin
          addr_q = r[8:4];
        end
      end else if (wb) begin
        we_q = 1'b0;
      end
    end
    report_test(5, "EX/WB register and load port");
  endtask

  task automatic ready_valid_test();
    logic [31:0] r;
    for (int i = 0; i < ITEMS; i++) begin
      r = next_rand();
      @(posedge clk);
      // Low word multiplies only, so no high word op is pending
      drive_enables(r[0], r[1], r[2], r[3]);
      mult_req     <= {MULT_MUL, next_rand(), next_rand()};
      lsu_ready_ex <= r[4];
      wb_ready     <= r[5];
      branch_in_ex <= r[6];
      @(negedge clk);
      check_value("mult_multicycle_o", 32'(mult_multicycle), 32'd0);
      check_value("ex_ready_o", 32'(ex_ready), 32'((r[4] & r[5]) | r[6]));
      check_value("ex_valid_o", 32'(ex_valid), 32'((|r[3:0]) & r[4] & r[5]));
    end
    report_test(6, "ready and valid levels");
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    hi_cycles   = DUT.MULT_HI_CYCLES;
    cycle_limit = NUM_TESTS * ITEMS * (hi_cycles + 2) + 100;
    rst_n             = 1'b0;
    alu_en            = 1'b0;
    alu_req           = '0;
    alu_operand_c     = '0;
    mult_en           = 1'b0;
    mult_req          = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    lsu_en            = 1'b0;
    lsu_rdata         = '0;
    lsu_ready_ex      = 1'b1;
    branch_in_ex      = 1'b0;
    wb_ready          = 1'b1;
    regfile_alu_we    = 1'b0;
    regfile_we        = 1'b0;
    regfile_alu_waddr = '0;
    regfile_waddr     = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    alu_result_test();
    branch_compare_test();
    multiply_test();
    forward_priority_test();
    load_port_test();
    ready_valid_test();
    @(posedge clk);
    $display("Tests run %0d, checks %0d, errors %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+verification
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_control.sv
source/ex_stage.sv
verification/tb_ex_stage.sv
